// ==== design/dcache_pkg.sv ====
package dcache_pkg;

    // Bus and memory geometry
    localparam int DATA_W      = 32;
    localparam int ADDR_W      = 12;                  // 4 KiB byte space
    localparam int BYTE_OFF_W  = 2;
    localparam int WORD_ADDR_W = ADDR_W - BYTE_OFF_W; // Wishbone adr is a word address
    localparam int SEL_W       = DATA_W / 8;
    localparam int MEM_WORDS   = 1024;

    // Cache geometry
    localparam int LINE_WORDS = 4;
    localparam int NUM_LINES  = 4;
    localparam int OFFSET_W   = $clog2(LINE_WORDS);
    localparam int INDEX_W    = $clog2(NUM_LINES);
    localparam int TAG_W      = WORD_ADDR_W - INDEX_W - OFFSET_W;

    // RISC-V load/store funct3
    localparam int F3_WIDTH = 3;
    localparam logic [F3_WIDTH-1:0] F3_B  = 3'b000;
    localparam logic [F3_WIDTH-1:0] F3_H  = 3'b001;
    localparam logic [F3_WIDTH-1:0] F3_W  = 3'b010;
    localparam logic [F3_WIDTH-1:0] F3_BU = 3'b100;
    localparam logic [F3_WIDTH-1:0] F3_HU = 3'b101;

    // Cache controller states
    localparam int STATE_W = 3;
    localparam logic [STATE_W-1:0] ST_IDLE    = 3'd0;
    localparam logic [STATE_W-1:0] ST_LOOKUP  = 3'd1;
    localparam logic [STATE_W-1:0] ST_WBACK   = 3'd2;
    localparam logic [STATE_W-1:0] ST_REFILL  = 3'd3;
    localparam logic [STATE_W-1:0] ST_RESPOND = 3'd4;

    // One data word, seen whole or by lanes
    typedef union packed {
        logic [DATA_W-1:0]                w;
        logic [DATA_W/16-1:0][15:0]       h;
        logic [DATA_W/8-1:0][7:0]         b;
    } word_lanes_u;

endpackage

// ==== design/wb_if.sv ====
`timescale 1ns/1ps

// Wishbone classic, single-beat handshake
interface wb_if;

    logic                                cyc;
    logic                                stb;
    logic                                we;
    logic [dcache_pkg::SEL_W-1:0]        sel;
    logic [dcache_pkg::WORD_ADDR_W-1:0]  adr;
    logic [dcache_pkg::DATA_W-1:0]       dat_w;
    logic [dcache_pkg::DATA_W-1:0]       dat_r;
    logic                                ack;

    modport master (
        output cyc, stb, we, sel, adr, dat_w,
        input  dat_r, ack
    );

    modport slave (
        input  cyc, stb, we, sel, adr, dat_w,
        output dat_r, ack
    );

endinterface

// ==== design/lsu_align.sv ====
`timescale 1ns/1ps

module lsu_align (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                req_valid,
    input  logic                                req_we,
    input  logic [dcache_pkg::F3_WIDTH-1:0]     req_funct3,
    input  logic [dcache_pkg::ADDR_W-1:0]       req_addr,
    input  logic [dcache_pkg::DATA_W-1:0]       req_wdata,
    output logic                                req_ready,
    output logic                                resp_valid,
    output logic [dcache_pkg::DATA_W-1:0]       resp_rdata,
    output logic                                resp_hit,
    wb_if.master                                cpu,
    input  logic                                cpu_hit
);

    logic                                    accept;
    logic [dcache_pkg::F3_WIDTH-1:0]         f3_r;
    logic [dcache_pkg::BYTE_OFF_W-1:0]       boff_r;
    logic [dcache_pkg::SEL_W-1:0]            sel_c;
    logic                                    misaligned;
    dcache_pkg::word_lanes_u                 st_lanes;
    dcache_pkg::word_lanes_u                 ld_lanes;
    logic [dcache_pkg::DATA_W-1:0]           ld_ext;

    assign accept   = req_valid && req_ready;
    assign ld_lanes = cpu.dat_r;

    // Store lane replication and byte enables
    always_comb begin
        st_lanes.w = req_wdata;
        sel_c      = '1;
        misaligned = 1'b0;
        case (req_funct3[1:0])
            2'b00: begin
                st_lanes.b = {4{req_wdata[7:0]}};
                sel_c      = 4'b0001 << req_addr[1:0];
            end
            2'b01: begin
                st_lanes.h = {2{req_wdata[15:0]}};
                sel_c      = 4'b0011 << {req_addr[1], 1'b0};
                misaligned = req_addr[0];
            end
            default: misaligned = |req_addr[1:0];
        endcase
    end

    always_comb begin
        case (f3_r)
            dcache_pkg::F3_B:  ld_ext = {{24{ld_lanes.b[boff_r][7]}}, ld_lanes.b[boff_r]};
            dcache_pkg::F3_BU: ld_ext = {24'b0, ld_lanes.b[boff_r]};
            dcache_pkg::F3_H:  ld_ext = {{16{ld_lanes.h[boff_r[1]][15]}}, ld_lanes.h[boff_r[1]]};
            dcache_pkg::F3_HU: ld_ext = {16'b0, ld_lanes.h[boff_r[1]]};
            default:           ld_ext = ld_lanes.w;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            req_ready  <= 1'b0;
            resp_valid <= 1'b0;
            cpu.cyc    <= 1'b0;
            cpu.stb    <= 1'b0;
        end else begin
            resp_valid <= 1'b0;
            if (accept) begin
                req_ready <= 1'b0;
                cpu.cyc   <= 1'b1;
                cpu.stb   <= 1'b1;
            end else if (cpu.ack) begin
                cpu.cyc    <= 1'b0;
                cpu.stb    <= 1'b0;
                resp_valid <= 1'b1;
            end else if (!cpu.cyc) begin
                req_ready <= 1'b1;        // Back to ready once the response is out
            end
        end
    end

    // Blocking request register
    always_ff @(posedge clk) begin
        if (accept) begin
            f3_r      <= req_funct3;
            boff_r    <= req_addr[dcache_pkg::BYTE_OFF_W-1:0];
            cpu.we    <= req_we;
            cpu.adr   <= req_addr[dcache_pkg::ADDR_W-1:dcache_pkg::BYTE_OFF_W];
            cpu.sel   <= sel_c;
            cpu.dat_w <= st_lanes.w;
        end
        if (cpu.ack) begin
            resp_rdata <= ld_ext;
            resp_hit   <= cpu_hit;
        end
    end

    a_aligned: assert property (@(posedge clk) disable iff (reset) accept |-> !misaligned)
        else $error("lsu_align: misaligned access at 0x%h", req_addr);

endmodule

// ==== design/dcache.sv ====
`timescale 1ns/1ps

module dcache (
    input  logic  clk,
    input  logic  reset,
    wb_if.slave   cpu,
    output logic  cpu_hit,
    wb_if.master  mem
);

    logic [dcache_pkg::DATA_W-1:0]   data_arr [dcache_pkg::NUM_LINES][dcache_pkg::LINE_WORDS];
    logic [dcache_pkg::TAG_W-1:0]    tag_arr  [dcache_pkg::NUM_LINES];
    logic [dcache_pkg::NUM_LINES-1:0] valid;
    logic [dcache_pkg::NUM_LINES-1:0] dirty;

    logic [dcache_pkg::STATE_W-1:0]  state;
    logic [dcache_pkg::OFFSET_W-1:0] beat;
    logic [dcache_pkg::TAG_W-1:0]    burst_tag;

    logic [dcache_pkg::OFFSET_W-1:0] off;
    logic [dcache_pkg::INDEX_W-1:0]  idx;
    logic [dcache_pkg::TAG_W-1:0]    tag;
    logic                            hit;
    logic                            victim_dirty;
    logic                            serve;

    dcache_pkg::word_lanes_u         old_w;
    dcache_pkg::word_lanes_u         new_w;
    dcache_pkg::word_lanes_u         merged;

    // Request fields, held stable by the master until ack
    assign off = cpu.adr[dcache_pkg::OFFSET_W-1:0];
    assign idx = cpu.adr[dcache_pkg::OFFSET_W +: dcache_pkg::INDEX_W];
    assign tag = cpu.adr[dcache_pkg::WORD_ADDR_W-1 -: dcache_pkg::TAG_W];

    assign hit          = valid[idx] && (tag_arr[idx] == tag);
    assign victim_dirty = valid[idx] && dirty[idx];
    assign serve        = ((state == dcache_pkg::ST_LOOKUP) && hit)
                          || (state == dcache_pkg::ST_RESPOND);

    // Byte merge under sel
    assign old_w = data_arr[idx][off];
    assign new_w = cpu.dat_w;
    always_comb begin
        merged = old_w;
        for (int i = 0; i < dcache_pkg::SEL_W; i++) begin
            if (cpu.sel[i]) merged.b[i] = new_w.b[i];
        end
    end

    // Line burst, one word per beat
    assign mem.adr   = {burst_tag, idx, beat};
    assign mem.dat_w = data_arr[idx][beat];
    assign mem.we    = (state == dcache_pkg::ST_WBACK);
    assign mem.sel   = '1;

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= dcache_pkg::ST_IDLE;
            beat    <= '0;
            valid   <= '0;
            dirty   <= '0;
            cpu.ack <= 1'b0;
            cpu_hit <= 1'b0;
            mem.cyc <= 1'b0;
            mem.stb <= 1'b0;
        end else begin
            cpu.ack <= 1'b0;
            if (serve) begin
                cpu.ack <= 1'b1;
                cpu_hit <= (state == dcache_pkg::ST_LOOKUP);
                if (cpu.we) dirty[idx] <= 1'b1;
            end
            case (state)
                dcache_pkg::ST_IDLE: begin
                    if (cpu.cyc && cpu.stb && !cpu.ack) state <= dcache_pkg::ST_LOOKUP;
                end
                dcache_pkg::ST_LOOKUP: begin
                    if (hit) begin
                        state <= dcache_pkg::ST_IDLE;
                    end else begin
                        mem.cyc <= 1'b1;
                        mem.stb <= 1'b1;
                        beat    <= '0;
                        state   <= victim_dirty ? dcache_pkg::ST_WBACK : dcache_pkg::ST_REFILL;
                    end
                end
                dcache_pkg::ST_WBACK: begin
                    if (mem.ack) begin
                        beat <= beat + 1'b1;
                        if (&beat) state <= dcache_pkg::ST_REFILL;   // Last word out
                    end
                end
                dcache_pkg::ST_REFILL: begin
                    if (mem.ack) begin
                        beat <= beat + 1'b1;
                        if (&beat) begin
                            mem.cyc    <= 1'b0;
                            mem.stb    <= 1'b0;
                            valid[idx] <= 1'b1;
                            dirty[idx] <= 1'b0;
                            state      <= dcache_pkg::ST_RESPOND;
                        end
                    end
                end
                dcache_pkg::ST_RESPOND: state <= dcache_pkg::ST_IDLE;
                default:                state <= dcache_pkg::ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (serve) begin
            cpu.dat_r <= old_w.w;
            if (cpu.we) data_arr[idx][off] <= merged.w;
        end
        if ((state == dcache_pkg::ST_LOOKUP) && !hit)
            burst_tag <= victim_dirty ? tag_arr[idx] : tag;
        if ((state == dcache_pkg::ST_WBACK) && mem.ack && (&beat))
            burst_tag <= tag;                      // Switch to the refill line
        if ((state == dcache_pkg::ST_REFILL) && mem.ack) begin
            data_arr[idx][beat] <= mem.dat_r;
            if (&beat) tag_arr[idx] <= tag;
        end
    end

    a_cpu_ack_stb: assert property (@(posedge clk) disable iff (reset) cpu.ack |-> cpu.stb)
        else $error("dcache: cpu ack without stb");

    // Write-back and refill stay on one line
    a_burst_index: assert property (@(posedge clk) disable iff (reset)
        (mem.cyc && $past(mem.cyc)) |->
        (mem.adr[dcache_pkg::OFFSET_W +: dcache_pkg::INDEX_W]
         == $past(mem.adr[dcache_pkg::OFFSET_W +: dcache_pkg::INDEX_W])))
        else $error("dcache: index changed inside a burst");

endmodule

// ==== design/wb_memory.sv ====
`timescale 1ns/1ps

module wb_memory (
    input  logic  clk,
    input  logic  reset,
    wb_if.slave   bus
);

    logic [dcache_pkg::DATA_W-1:0] ram [dcache_pkg::MEM_WORDS];
    logic                          access;

    // New beat only when no ack went out last cycle
    assign access = bus.cyc && bus.stb && !bus.ack;

    initial begin
        for (int i = 0; i < dcache_pkg::MEM_WORDS; i++) begin
            ram[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            bus.ack <= 1'b0;
        end else begin
            bus.ack <= access;
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            if (bus.we) begin
                for (int i = 0; i < dcache_pkg::SEL_W; i++) begin
                    if (bus.sel[i]) ram[bus.adr][i*8 +: 8] <= bus.dat_w[i*8 +: 8];
                end
            end
            bus.dat_r <= ram[bus.adr];   // Old data on a write beat
        end
    end

    a_ack_stb: assert property (@(posedge clk) disable iff (reset) bus.ack |-> bus.stb)
        else $error("wb_memory: ack without stb");

endmodule

// ==== design/dcache_top.sv ====
`timescale 1ns/1ps

module dcache_top (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                req_valid,
    output logic                                req_ready,
    input  logic                                req_we,
    input  logic [dcache_pkg::F3_WIDTH-1:0]     req_funct3,
    input  logic [dcache_pkg::ADDR_W-1:0]       req_addr,
    input  logic [dcache_pkg::DATA_W-1:0]       req_wdata,
    output logic                                resp_valid,
    output logic [dcache_pkg::DATA_W-1:0]       resp_rdata,
    output logic                                resp_hit
);

    wb_if cpu_bus ();
    wb_if mem_bus ();

    logic cpu_hit;

    lsu_align u_lsu (
        .clk        (clk),
        .reset      (reset),
        .req_valid  (req_valid),
        .req_we     (req_we),
        .req_funct3 (req_funct3),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .req_ready  (req_ready),
        .resp_valid (resp_valid),
        .resp_rdata (resp_rdata),
        .resp_hit   (resp_hit),
        .cpu        (cpu_bus.master),
        .cpu_hit    (cpu_hit)
    );

    dcache u_dcache (
        .clk     (clk),
        .reset   (reset),
        .cpu     (cpu_bus.slave),
        .cpu_hit (cpu_hit),
        .mem     (mem_bus.master)
    );

    wb_memory u_mem (
        .clk   (clk),
        .reset (reset),
        .bus   (mem_bus.slave)
    );

endmodule

// ==== verification/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
    output logic clk
);

    localparam real HALF_PERIOD = 5.0;   // 10 ns period

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

endmodule

// ==== verification/dcache_tb.sv ====
`timescale 1ns/1ps

module dcache_tb;

    localparam int RESET_CYCLES = 4;
    localparam int N_DIRECTED   = 23;
    localparam int N_RANDOM     = 400;
    localparam int TIMEOUT      = (N_DIRECTED + N_RANDOM) * 25 + RESET_CYCLES;
    localparam logic [31:0] SEED = 32'h29f2_22ac;

    typedef struct {
        logic                          we;
        logic [dcache_pkg::ADDR_W-1:0] addr;
        logic [dcache_pkg::DATA_W-1:0] data;
        logic                          hit;
        int                            accept;
    } expect_t;

    logic                            clk;
    logic                            reset;
    logic                            req_valid;
    logic                            req_ready;
    logic                            req_we;
    logic [dcache_pkg::F3_WIDTH-1:0] req_funct3;
    logic [dcache_pkg::ADDR_W-1:0]   req_addr;
    logic [dcache_pkg::DATA_W-1:0]   req_wdata;
    logic                            resp_valid;
    logic [dcache_pkg::DATA_W-1:0]   resp_rdata;
    logic                            resp_hit;

    // Reference state
    logic [dcache_pkg::DATA_W-1:0] model_mem [dcache_pkg::MEM_WORDS];
    logic [dcache_pkg::TAG_W-1:0]  shadow_tag [dcache_pkg::NUM_LINES];
    logic [dcache_pkg::NUM_LINES-1:0] shadow_valid = '0;

    expect_t pending [$];
    int      cycle_count = 0;

    tb_clock u_clock (.clk(clk));

    dcache_top UUT (
        .clk        (clk),
        .reset      (reset),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req_we     (req_we),
        .req_funct3 (req_funct3),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .resp_valid (resp_valid),
        .resp_rdata (resp_rdata),
        .resp_hit   (resp_hit)
    );

    initial begin
        for (int i = 0; i < dcache_pkg::MEM_WORDS; i++) begin
            model_mem[i] = '0;
        end
    end

    task automatic fail_run();
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Expected load data and hit from the model memory and shadow tags
    function automatic logic [31:0] ref_access(input logic we, input logic [2:0] f3,
                                               input logic [11:0] addr, input logic [31:0] wdata,
                                               output logic hit);
        logic [9:0]  wa;
        logic [1:0]  idx;
        logic [5:0]  tag;
        logic [1:0]  boff;
        logic [31:0] word;
        logic [7:0]  b;
        logic [15:0] h;
        logic [31:0] result;
        wa   = addr[11:2];
        idx  = wa[dcache_pkg::OFFSET_W +: dcache_pkg::INDEX_W];
        tag  = wa[9 -: dcache_pkg::TAG_W];
        boff = addr[1:0];
        hit  = shadow_valid[idx] && (shadow_tag[idx] == tag);
        shadow_valid[idx] = 1'b1;           // Loads and stores both allocate
        shadow_tag[idx]   = tag;
        word   = model_mem[wa];
        b      = word[8*boff +: 8];
        h      = word[16*boff[1] +: 16];
        result = word;
        if (we) begin
            case (f3)
                dcache_pkg::F3_B: word[8*boff +: 8] = wdata[7:0];
                dcache_pkg::F3_H: word[16*boff[1] +: 16] = wdata[15:0];
                default:          word = wdata;
            endcase
            model_mem[wa] = word;
        end else begin
            case (f3)
                dcache_pkg::F3_B:  result = {{24{b[7]}}, b};
                dcache_pkg::F3_BU: result = {24'h0, b};
                dcache_pkg::F3_H:  result = {{16{h[15]}}, h};
                dcache_pkg::F3_HU: result = {16'h0, h};
                default:           result = word;
            endcase
        end
        return result;
    endfunction

    function automatic logic [2:0] load_f3(input logic [3:0] r);
        case (r % 5)
            0:       return dcache_pkg::F3_B;
            1:       return dcache_pkg::F3_H;
            2:       return dcache_pkg::F3_W;
            3:       return dcache_pkg::F3_BU;
            default: return dcache_pkg::F3_HU;
        endcase
    endfunction

    function automatic logic [2:0] store_f3(input logic [3:0] r);
        case (r % 3)
            0:       return dcache_pkg::F3_B;
            1:       return dcache_pkg::F3_H;
            default: return dcache_pkg::F3_W;
        endcase
    endfunction

    function automatic logic [11:0] align_for(input logic [2:0] f3, input logic [11:0] addr);
        case (f3[1:0])
            2'b00:   return addr;
            2'b01:   return {addr[11:1], 1'b0};
            default: return {addr[11:2], 2'b00};
        endcase
    endfunction

    // Drive one request on falling edges and queue its expected response
    task automatic issue(input logic we, input logic [2:0] f3,
                         input logic [11:0] addr, input logic [31:0] wdata);
        expect_t e;
        logic    hit_exp;
        @(negedge clk);
        req_valid  = 1'b1;
        req_we     = we;
        req_funct3 = f3;
        req_addr   = addr;
        req_wdata  = wdata;
        while (!req_ready) @(negedge clk);
        e.data   = ref_access(we, f3, addr, wdata, hit_exp);
        e.hit    = hit_exp;
        e.we     = we;
        e.addr   = addr;
        e.accept = cycle_count + 1;         // Taken on the coming rising edge
        pending.push_back(e);
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > TIMEOUT) begin
            $display("Timeout: run still busy after %0d cycles", TIMEOUT);
            fail_run();
        end
    end

    // Compare every response against the queued expectation
    always @(negedge clk) begin
        expect_t e;
        if (!reset && resp_valid) begin
            if (pending.size() == 0) begin
                $display("Response arrived with no request outstanding");
                fail_run();
            end else begin
                e = pending.pop_front();
                assert (req_ready === 1'b0) else begin
                    $display("[ERROR] req_ready expected 0x0 actual 0x%h (addr 0x%h)",
                             req_ready, e.addr);
                    fail_run();
                end
                assert (resp_hit === e.hit) else begin
                    $display("[ERROR] resp_hit expected 0x%h actual 0x%h (addr 0x%h)",
                             e.hit, resp_hit, e.addr);
                    fail_run();
                end
                if (!e.we) begin
                    assert (resp_rdata === e.data) else begin
                        $display("[ERROR] resp_rdata expected 0x%h actual 0x%h (addr 0x%h)",
                                 e.data, resp_rdata, e.addr);
                        fail_run();
                    end
                end
                if (e.hit) begin
                    assert (cycle_count - e.accept == 3) else begin
                        $display("[ERROR] resp_valid latency expected 0x3 actual 0x%h",
                                 cycle_count - e.accept);
                        fail_run();
                    end
                end
            end
        end
    end

    initial begin : stimulus
        logic [31:0] rng;
        logic        op_we;
        logic [2:0]  op_f3;
        logic [11:0] op_addr;
        reset      = 1'b1;
        req_valid  = 1'b0;
        req_we     = 1'b0;
        req_funct3 = '0;
        req_addr   = '0;
        req_wdata  = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        assert (req_ready === 1'b1 && resp_valid === 1'b0) else begin
            $display("[ERROR] req_ready/resp_valid expected 0x1/0x0 actual 0x%h/0x%h",
                     req_ready, resp_valid);
            fail_run();
        end

        issue(1'b0, dcache_pkg::F3_W, 12'h3f0, 32'h0);           // Cold miss reads zero

        issue(1'b1, dcache_pkg::F3_W, 12'h010, 32'hcafe_f00d);
        issue(1'b0, dcache_pkg::F3_W, 12'h010, 32'h0);

        // Sub-word lanes and extension
        issue(1'b1, dcache_pkg::F3_W,  12'h044, 32'h7f3a_5c81);
        issue(1'b1, dcache_pkg::F3_B,  12'h045, 32'h1234_5696);
        issue(1'b1, dcache_pkg::F3_H,  12'h046, 32'hffff_8123);
        issue(1'b0, dcache_pkg::F3_B,  12'h044, 32'h0);
        issue(1'b0, dcache_pkg::F3_BU, 12'h044, 32'h0);
        issue(1'b0, dcache_pkg::F3_B,  12'h045, 32'h0);
        issue(1'b0, dcache_pkg::F3_B,  12'h047, 32'h0);
        issue(1'b0, dcache_pkg::F3_H,  12'h044, 32'h0);
        issue(1'b0, dcache_pkg::F3_HU, 12'h046, 32'h0);
        issue(1'b0, dcache_pkg::F3_H,  12'h046, 32'h0);
        issue(1'b0, dcache_pkg::F3_W,  12'h044, 32'h0);
        issue(1'b1, dcache_pkg::F3_H,  12'h048, 32'hdead_1234);
        issue(1'b1, dcache_pkg::F3_B,  12'h04b, 32'h0000_005a);
        issue(1'b0, dcache_pkg::F3_H,  12'h048, 32'h0);
        issue(1'b0, dcache_pkg::F3_B,  12'h04b, 32'h0);
        issue(1'b0, dcache_pkg::F3_W,  12'h048, 32'h0);

        // Same index, two tags, dirty victims both ways
        issue(1'b1, dcache_pkg::F3_W, 12'h100, 32'hdead_beef);
        issue(1'b1, dcache_pkg::F3_W, 12'h140, 32'h1357_9bdf);
        issue(1'b0, dcache_pkg::F3_W, 12'h100, 32'h0);
        issue(1'b0, dcache_pkg::F3_W, 12'h140, 32'h0);

        // 256 byte window over four lines keeps conflicts frequent
        rng = SEED;
        for (int n = 0; n < N_RANDOM; n++) begin
            rng     = xorshift(rng);
            op_we   = rng[0];
            op_f3   = op_we ? store_f3(rng[7:4]) : load_f3(rng[7:4]);
            op_addr = align_for(op_f3, {4'h2, rng[15:8]});
            rng     = xorshift(rng);
            issue(op_we, op_f3, op_addr, rng);
        end

        while (pending.size() != 0) @(negedge clk);
        repeat (2) @(negedge clk);
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// ==== tb.f ====
design/dcache_pkg.sv
design/wb_if.sv
design/lsu_align.sv
design/dcache.sv
design/wb_memory.sv
design/dcache_top.sv
verification/tb_clock.sv
verification/dcache_tb.sv

// ==== Bender.yml ====
package:
  name: dcache

sources:
  - design/dcache_pkg.sv
  - design/wb_if.sv
  - design/lsu_align.sv
  - design/dcache.sv
  - design/wb_memory.sv
  - design/dcache_top.sv
  - target: test
    files:
      - verification/tb_clock.sv
      - verification/dcache_tb.sv
